// File: verilog/ooo_pipe_cfg.svh
`ifndef OOO_PIPE_CFG_SVH
`define OOO_PIPE_CFG_SVH

// width of pc and address values
`define XLEN 32

// architectural register index, 32 registers
`define REG_IDX_W 5

// reorder buffer entries
`define ROB_DEPTH 8

// count runs 0..ROB_DEPTH, so one bit wider than the index
`define ROB_CNT_W 4

`endif

// File: verilog/hazard_types_pkg.sv
`default_nettype none

package hazard_types_pkg;

  // functional unit that the decoded instruction is issued to
  typedef enum logic [1:0] {
    ALU_S       = 2'd0,
    MUL_S       = 2'd1,
    DIV_S       = 2'd2,
    LOADSTORE_S = 2'd3
  } fu_type_t;

  // operand source select from decode
  // the two register encodings need a scoreboard lookup, imm and pc do not
  // a loadstore op with source a on SRC_RS_ALT is a store
  typedef enum logic [1:0] {
    SRC_RS     = 2'd0,
    SRC_RS_ALT = 2'd1,
    SRC_IMM    = 2'd2,
    SRC_PC     = 2'd3
  } src_sel_t;

endpackage

`default_nettype wire

// File: verilog/trap_types_pkg.sv
`default_nettype none

package trap_types_pkg;

  // trap sequencer states
  //   run      normal issue
  //   drain    interrupt seen, waiting for the rob to empty
  //   redirect new pc sent to fetch, waiting for the imem hit
  typedef enum logic [1:0] {
    TRAP_RUN      = 2'd0,
    TRAP_DRAIN    = 2'd1,
    TRAP_REDIRECT = 2'd2
  } trap_state_t;

endpackage

`default_nettype wire

// File: verilog/reg_busy_scoreboard.sv
`include "ooo_pipe_cfg.svh"

`default_nettype none

module reg_busy_scoreboard (
  input  logic                  CLK,
  input  logic                  rst_n,
  // dispatch side sets the destination
  input  logic                  dispatch,
  input  logic [`REG_IDX_W-1:0] dispatch_rd,
  input  logic                  dispatch_wen,
  // completion side clears it again
  input  logic                  complete,
  input  logic [`REG_IDX_W-1:0] complete_rd,
  input  logic                  flush_all,
  // decode lookups
  input  logic [`REG_IDX_W-1:0] rs1,
  input  logic [`REG_IDX_W-1:0] rs2,
  input  logic [`REG_IDX_W-1:0] rd,
  output logic                  rs1_busy,
  output logic                  rs2_busy,
  output logic                  rd_busy
);

  localparam int NUM_REGS = 1 << `REG_IDX_W;

  // one pending-write bit per architectural register
  logic [NUM_REGS-1:0] busy;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
    end else if (flush_all) begin
      // squashed instructions never complete, drop all pending writes
      busy <= '0;
    end else begin
      if (complete) begin
        busy[complete_rd] <= 1'b0;
      end
      // later assignment wins, so a same-cycle dispatch keeps the bit set
      if (dispatch && dispatch_wen && (dispatch_rd != '0)) begin
        busy[dispatch_rd] <= 1'b1;
      end
    end
  end

  // x0 is hardwired, its bit is never set
  assign rs1_busy = busy[rs1];
  assign rs2_busy = busy[rs2];
  assign rd_busy  = busy[rd];

endmodule

`default_nettype wire

// File: verilog/rob_occupancy_counter.sv
`include "ooo_pipe_cfg.svh"

`default_nettype none

module rob_occupancy_counter (
  input  logic CLK,
  input  logic rst_n,
  input  logic dispatch,
  input  logic commit,
  input  logic flush_all,
  output logic rob_full,
  output logic rob_empty
);

  localparam logic [`ROB_CNT_W-1:0] FULL_CNT = `ROB_CNT_W'(`ROB_DEPTH);

  // instructions between dispatch and commit
  logic [`ROB_CNT_W-1:0] count;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (flush_all) begin
      count <= '0;
    end else begin
      case ({dispatch, commit})
        2'b10: begin
          // guarded so the count cannot pass the rob size
          if (!rob_full) count <= count + 1'b1;
        end
        2'b01: begin
          if (!rob_empty) count <= count - 1'b1;
        end
        // both or neither, the occupancy stays the same
        default: count <= count;
      endcase
    end
  end

  assign rob_full  = (count == FULL_CNT);
  assign rob_empty = (count == '0);

endmodule

`default_nettype wire

// File: verilog/trap_sequencer.sv
`default_nettype none

module trap_sequencer (
  input  logic CLK,
  input  logic rst_n,
  input  logic intr_pending,
  input  logic rob_empty,
  input  logic redirect,
  input  logic ihit,
  output logic intr_taken,
  output logic update_pc_wait_ihit
);

  trap_types_pkg::trap_state_t state;
  trap_types_pkg::trap_state_t state_next;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state <= trap_types_pkg::TRAP_RUN;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      trap_types_pkg::TRAP_RUN: begin
        // an interrupt takes priority, its own redirect follows the drain
        if (intr_pending) begin
          state_next = trap_types_pkg::TRAP_DRAIN;
        end else if (redirect && !ihit) begin
          state_next = trap_types_pkg::TRAP_REDIRECT;
        end
      end
      trap_types_pkg::TRAP_DRAIN: begin
        if (rob_empty) begin
          // interrupt accepted this cycle, fetch restarts at the handler
          state_next = trap_types_pkg::TRAP_REDIRECT;
        end else if (!intr_pending) begin
          // request withdrawn before the rob drained
          state_next = trap_types_pkg::TRAP_RUN;
        end
      end
      trap_types_pkg::TRAP_REDIRECT: begin
        if (ihit) state_next = trap_types_pkg::TRAP_RUN;
      end
      default: state_next = trap_types_pkg::TRAP_RUN;
    endcase
  end

  // single-cycle pulse, the drain state is left on the same edge
  assign intr_taken = (state == trap_types_pkg::TRAP_DRAIN) && rob_empty;

  // hold the pipe until the redirected fetch returns
  assign update_pc_wait_ihit = (state == trap_types_pkg::TRAP_REDIRECT) && !ihit;

endmodule

`default_nettype wire

// File: verilog/ooo_hazard_unit.sv
`include "ooo_pipe_cfg.svh"

`default_nettype none

module ooo_hazard_unit (
  input  logic                         ihit,
  input  logic                         i_mem_busy,
  // decode stage
  input  logic                         decode_valid,
  input  hazard_types_pkg::fu_type_t   fu_type,
  input  hazard_types_pkg::src_sel_t   source_a_sel,
  input  hazard_types_pkg::src_sel_t   source_b_sel,
  input  logic [`REG_IDX_W-1:0]        rd,
  input  logic                         wen,
  input  logic                         csr,
  // functional unit state
  input  logic                         busy_du,
  input  logic                         busy_ls,
  input  logic                         wb_port_conflict,
  input  logic                         mispredict,
  input  logic                         cb_flush,
  // exceptions reported at commit
  input  logic                         fault_insn,
  input  logic                         mal_insn,
  input  logic                         illegal_insn,
  input  logic                         fault_l,
  input  logic                         mal_l,
  input  logic                         fault_s,
  input  logic                         mal_s,
  input  logic                         breakpoint,
  input  logic                         env_m,
  input  logic                         ret,
  // privilege block
  input  logic                         prv_intr,
  input  logic                         prv_insert_pc,
  input  logic [`XLEN-1:0]             prv_priv_pc,
  input  logic [`XLEN-1:0]             pc_ex,
  input  logic [`XLEN-1:0]             pc_fe,
  input  logic [`XLEN-1:0]             cb_epc,
  input  logic [`XLEN-1:0]             badaddr_d,
  // from scoreboard, rob counter and trap sequencer
  input  logic                         rs1_busy,
  input  logic                         rs2_busy,
  input  logic                         rd_busy,
  input  logic                         rob_full,
  input  logic                         rob_empty,
  input  logic                         intr_taken,
  input  logic                         update_pc_wait_ihit,
  output logic                         pc_en,
  output logic                         stall_fetch_decode,
  output logic                         fetch_decode_flush,
  output logic                         decode_execute_flush,
  output logic                         execute_commit_flush,
  output logic                         npc_sel,
  output logic                         insert_priv_pc,
  output logic [`XLEN-1:0]             priv_pc,
  output logic [`XLEN-1:0]             epc,
  output logic [`XLEN-1:0]             badaddr,
  output logic                         pipe_clear,
  output logic                         wb_enable,
  output logic                         dispatch,
  output logic [`REG_IDX_W-1:0]        dispatch_rd,
  output logic                         dispatch_wen,
  output logic                         flush_all,
  output logic                         intr_pending,
  output logic                         redirect
);

  logic rs1_read, rs2_read;
  logic data_hazard, structural_hazard;
  logic store;
  logic commit_exception, exception_from_cb;
  logic intr_active;

  // imm and pc operands never touch the register file
  assign rs1_read = (source_a_sel == hazard_types_pkg::SRC_RS) ||
                    (source_a_sel == hazard_types_pkg::SRC_RS_ALT);
  assign rs2_read = (source_b_sel == hazard_types_pkg::SRC_RS) ||
                    (source_b_sel == hazard_types_pkg::SRC_RS_ALT);

  // raw on read operands, waw on the destination
  assign data_hazard = (rs1_busy && rs1_read) || (rs2_busy && rs2_read) || (rd_busy && wen);

  assign structural_hazard = ((fu_type == hazard_types_pkg::DIV_S) && busy_du) ||
                             ((fu_type == hazard_types_pkg::LOADSTORE_S) && busy_ls) ||
                             wb_port_conflict;

  // stores go out in order, only with nothing older in flight
  assign store = (fu_type == hazard_types_pkg::LOADSTORE_S) &&
                 (source_a_sel == hazard_types_pkg::SRC_RS_ALT);

  assign commit_exception = fault_insn | mal_insn | illegal_insn | fault_l | mal_l |
                            fault_s | mal_s | breakpoint | env_m;
  assign exception_from_cb = mal_insn | illegal_insn | mal_l | mal_s;

  // exception at commit beats a pending interrupt
  assign intr_pending = prv_intr && !commit_exception;
  assign intr_active  = intr_pending || intr_taken;

  assign stall_fetch_decode = intr_pending | csr | rob_full | update_pc_wait_ihit |
                              data_hazard | structural_hazard | (store && !rob_empty);
  assign pc_en = !(stall_fetch_decode || i_mem_busy);

  // dispatch into the rob and scoreboard
  assign dispatch     = decode_valid && !stall_fetch_decode;
  assign dispatch_rd  = rd;
  assign dispatch_wen = wen;
  assign flush_all    = cb_flush;

  // redirects
  assign npc_sel        = mispredict;
  assign insert_priv_pc = prv_insert_pc;
  assign priv_pc        = prv_priv_pc;
  assign redirect       = npc_sel | csr | prv_insert_pc;

  assign fetch_decode_flush   = npc_sel | prv_insert_pc | csr | cb_flush;
  // the decode latch only takes a bubble once fetch has returned
  assign decode_execute_flush = (npc_sel | prv_insert_pc | cb_flush) & ihit;
  assign execute_commit_flush = csr | cb_flush;

  // ecall and ebreak report the execute pc, completion buffer faults their own pc
  assign epc = (breakpoint || env_m) ? pc_ex :
               exception_from_cb     ? cb_epc :
                                       pc_fe;
  // instruction side faults report the fetch address, data side the memory address
  assign badaddr = (mal_insn || fault_insn) ? cb_epc : badaddr_d;

  assign pipe_clear = intr_active ? rob_empty : (cb_flush | breakpoint | env_m | ret);
  assign wb_enable  = !stall_fetch_decode && !npc_sel;

endmodule

`default_nettype wire

// File: verilog/ooo_pipe_control.sv
`include "ooo_pipe_cfg.svh"

`default_nettype none

module ooo_pipe_control (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic                       ihit,
  input  logic                       i_mem_busy,
  input  logic                       decode_valid,
  input  hazard_types_pkg::fu_type_t fu_type,
  input  hazard_types_pkg::src_sel_t source_a_sel,
  input  hazard_types_pkg::src_sel_t source_b_sel,
  input  logic [`REG_IDX_W-1:0]      rs1,
  input  logic [`REG_IDX_W-1:0]      rs2,
  input  logic [`REG_IDX_W-1:0]      rd,
  input  logic                       wen,
  input  logic                       csr,
  input  logic                       busy_du,
  input  logic                       busy_ls,
  input  logic                       wb_port_conflict,
  input  logic                       mispredict,
  input  logic                       cb_flush,
  input  logic                       complete,
  input  logic [`REG_IDX_W-1:0]      complete_rd,
  input  logic                       commit,
  input  logic                       fault_insn,
  input  logic                       mal_insn,
  input  logic                       illegal_insn,
  input  logic                       fault_l,
  input  logic                       mal_l,
  input  logic                       fault_s,
  input  logic                       mal_s,
  input  logic                       breakpoint,
  input  logic                       env_m,
  input  logic                       ret,
  input  logic                       prv_intr,
  input  logic                       prv_insert_pc,
  input  logic [`XLEN-1:0]           prv_priv_pc,
  input  logic [`XLEN-1:0]           pc_ex,
  input  logic [`XLEN-1:0]           pc_fe,
  input  logic [`XLEN-1:0]           cb_epc,
  input  logic [`XLEN-1:0]           badaddr_d,
  output logic                       pc_en,
  output logic                       stall_fetch_decode,
  output logic                       fetch_decode_flush,
  output logic                       decode_execute_flush,
  output logic                       execute_commit_flush,
  output logic                       npc_sel,
  output logic                       insert_priv_pc,
  output logic [`XLEN-1:0]           priv_pc,
  output logic [`XLEN-1:0]           epc,
  output logic [`XLEN-1:0]           badaddr,
  output logic                       pipe_clear,
  output logic                       wb_enable,
  output logic                       rob_full,
  output logic                       rob_empty,
  output logic                       intr_taken
);

  // hazard unit to the state blocks
  logic                  dispatch;
  logic [`REG_IDX_W-1:0] dispatch_rd;
  logic                  dispatch_wen;
  logic                  flush_all;
  logic                  intr_pending;
  logic                  redirect;
  // state blocks back to the hazard unit
  logic                  rs1_busy, rs2_busy, rd_busy;
  logic                  update_pc_wait_ihit;

  ooo_hazard_unit i_hazard (
    .ihit, .i_mem_busy, .decode_valid, .fu_type, .source_a_sel, .source_b_sel,
    .rd, .wen, .csr, .busy_du, .busy_ls, .wb_port_conflict, .mispredict, .cb_flush,
    .fault_insn, .mal_insn, .illegal_insn, .fault_l, .mal_l, .fault_s, .mal_s,
    .breakpoint, .env_m, .ret,
    .prv_intr, .prv_insert_pc, .prv_priv_pc, .pc_ex, .pc_fe, .cb_epc, .badaddr_d,
    .rs1_busy, .rs2_busy, .rd_busy, .rob_full, .rob_empty,
    .intr_taken, .update_pc_wait_ihit,
    .pc_en, .stall_fetch_decode,
    .fetch_decode_flush, .decode_execute_flush, .execute_commit_flush,
    .npc_sel, .insert_priv_pc, .priv_pc, .epc, .badaddr, .pipe_clear, .wb_enable,
    .dispatch, .dispatch_rd, .dispatch_wen, .flush_all, .intr_pending, .redirect
  );

  reg_busy_scoreboard i_scoreboard (
    .CLK, .rst_n,
    .dispatch, .dispatch_rd, .dispatch_wen,
    .complete, .complete_rd, .flush_all,
    .rs1, .rs2, .rd,
    .rs1_busy, .rs2_busy, .rd_busy
  );

  rob_occupancy_counter i_rob_count (
    .CLK, .rst_n, .dispatch, .commit, .flush_all, .rob_full, .rob_empty
  );

  trap_sequencer i_trap_seq (
    .CLK, .rst_n, .intr_pending, .rob_empty, .redirect, .ihit,
    .intr_taken, .update_pc_wait_ihit
  );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic CLK,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  localparam int HALF_PERIOD = 10;

  initial begin
    CLK = 1'b0;
    forever #(HALF_PERIOD) CLK = ~CLK;
  end

  // reset held over two rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/tb_ooo_pipe_control.sv
`include "ooo_pipe_cfg.svh"

`default_nettype none

module tb_ooo_pipe_control;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 20;
  // six tests of at most two rob fills plus a few setup cycles each
  localparam int TEST_CYCLES = 6 * (2 * `ROB_DEPTH + 8);
  localparam int MARGIN_CYCLES = 50;

  logic CLK, rst_n;
  logic ihit, i_mem_busy, decode_valid, wen, csr;
  hazard_types_pkg::fu_type_t fu_type;
  hazard_types_pkg::src_sel_t source_a_sel, source_b_sel;
  logic [`REG_IDX_W-1:0] rs1, rs2, rd, complete_rd;
  logic busy_du, busy_ls, wb_port_conflict, mispredict, cb_flush, complete, commit;
  logic fault_insn, mal_insn, illegal_insn, fault_l, mal_l, fault_s, mal_s;
  logic breakpoint, env_m, ret, prv_intr, prv_insert_pc;
  logic [`XLEN-1:0] prv_priv_pc, pc_ex, pc_fe, cb_epc, badaddr_d;
  logic pc_en, stall_fetch_decode, fetch_decode_flush, decode_execute_flush;
  logic execute_commit_flush, npc_sel, insert_priv_pc, pipe_clear, wb_enable;
  logic [`XLEN-1:0] priv_pc, epc, badaddr;
  logic rob_full, rob_empty, intr_taken;

  int err_count;
  int err_mark;
  int tests_run;
  logic [15:0] lfsr_state;

  // reference model of busy bits, rob count and sequencer state
  logic [(1 << `REG_IDX_W)-1:0] m_busy;
  int m_count;
  trap_types_pkg::trap_state_t m_state;

  logic exp_rs1_read, exp_rs2_read, exp_data_hz, exp_struct_hz, exp_store;
  logic exp_commit_exc, exp_intr_pending, exp_wait, exp_taken, exp_redirect;
  logic exp_stall, exp_dispatch, exp_pipe_clear;
  logic exp_fd_flush, exp_de_flush, exp_ec_flush;
  logic [`XLEN-1:0] exp_epc, exp_badaddr;

  tb_clock_gen i_clk_gen (.CLK, .rst_n);

  ooo_pipe_control i_dut (.*);

  // register read only for the two register encodings
  assign exp_rs1_read = (source_a_sel == hazard_types_pkg::SRC_RS) ||
                        (source_a_sel == hazard_types_pkg::SRC_RS_ALT);
  assign exp_rs2_read = (source_b_sel == hazard_types_pkg::SRC_RS) ||
                        (source_b_sel == hazard_types_pkg::SRC_RS_ALT);
  assign exp_data_hz = (m_busy[rs1] && exp_rs1_read) || (m_busy[rs2] && exp_rs2_read) ||
                       (m_busy[rd] && wen);
  assign exp_struct_hz = (fu_type == hazard_types_pkg::DIV_S && busy_du) ||
                         (fu_type == hazard_types_pkg::LOADSTORE_S && busy_ls) ||
                         wb_port_conflict;
  assign exp_store = (fu_type == hazard_types_pkg::LOADSTORE_S) &&
                     (source_a_sel == hazard_types_pkg::SRC_RS_ALT);
  assign exp_commit_exc = fault_insn || mal_insn || illegal_insn || fault_l || mal_l ||
                          fault_s || mal_s || breakpoint || env_m;
  assign exp_intr_pending = prv_intr && !exp_commit_exc;
  assign exp_redirect = mispredict || csr || prv_insert_pc;
  assign exp_wait = (m_state == trap_types_pkg::TRAP_REDIRECT) && !ihit;
  assign exp_taken = (m_state == trap_types_pkg::TRAP_DRAIN) && (m_count == 0);
  assign exp_stall = exp_intr_pending || csr || (m_count == `ROB_DEPTH) || exp_wait ||
                     exp_data_hz || exp_struct_hz || (exp_store && m_count != 0);
  assign exp_dispatch = decode_valid && !exp_stall;
  assign exp_fd_flush = mispredict || prv_insert_pc || csr || cb_flush;
  assign exp_de_flush = (mispredict || prv_insert_pc || cb_flush) && ihit;
  assign exp_ec_flush = csr || cb_flush;
  // ecall and ebreak first and then the completion buffer faults
  assign exp_epc = (breakpoint || env_m) ? pc_ex :
                   (mal_insn || illegal_insn || mal_l || mal_s) ? cb_epc : pc_fe;
  assign exp_badaddr = (fault_insn || mal_insn) ? cb_epc : badaddr_d;
  assign exp_pipe_clear = (exp_intr_pending || exp_taken) ? (m_count == 0) :
                          (cb_flush || breakpoint || env_m || ret);

  always @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      m_busy <= '0;
      m_count <= 0;
      m_state <= trap_types_pkg::TRAP_RUN;
    end else begin
      if (cb_flush) begin
        m_busy <= '0;
        m_count <= 0;
      end else begin
        if (complete) m_busy[complete_rd] <= 1'b0;
        // dispatch after completion so it wins on the same register
        if (exp_dispatch && wen && rd != '0) m_busy[rd] <= 1'b1;
        if (exp_dispatch && !commit) begin
          m_count <= m_count + 1;
        end else if (commit && !exp_dispatch) begin
          m_count <= m_count - 1;
        end
      end
      case (m_state)
        trap_types_pkg::TRAP_RUN: begin
          if (exp_intr_pending) m_state <= trap_types_pkg::TRAP_DRAIN;
          else if (exp_redirect && !ihit) m_state <= trap_types_pkg::TRAP_REDIRECT;
        end
        trap_types_pkg::TRAP_DRAIN: begin
          if (m_count == 0) m_state <= trap_types_pkg::TRAP_REDIRECT;
          else if (!exp_intr_pending) m_state <= trap_types_pkg::TRAP_RUN;
        end
        default: begin
          if (ihit) m_state <= trap_types_pkg::TRAP_RUN;
        end
      endcase
    end
  end

  task automatic fail_value(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    $display("Fail %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    err_count++;
  endtask

  a_stall: assert property (@(posedge CLK) disable iff (!rst_n)
    stall_fetch_decode == exp_stall)
    else fail_value("stall_fetch_decode",
                    32'($sampled(stall_fetch_decode)), 32'($sampled(exp_stall)));
  a_pc_en: assert property (@(posedge CLK) disable iff (!rst_n)
    pc_en == !(exp_stall || i_mem_busy))
    else fail_value("pc_en", 32'($sampled(pc_en)), 32'(!$sampled(exp_stall || i_mem_busy)));
  a_npc: assert property (@(posedge CLK) disable iff (!rst_n) npc_sel == mispredict)
    else fail_value("npc_sel", 32'($sampled(npc_sel)), 32'($sampled(mispredict)));
  a_insert_pc: assert property (@(posedge CLK) disable iff (!rst_n)
    insert_priv_pc == prv_insert_pc)
    else fail_value("insert_priv_pc",
                    32'($sampled(insert_priv_pc)), 32'($sampled(prv_insert_pc)));
  a_priv_pc: assert property (@(posedge CLK) disable iff (!rst_n) priv_pc == prv_priv_pc)
    else fail_value("priv_pc", $sampled(priv_pc), $sampled(prv_priv_pc));
  a_fd_flush: assert property (@(posedge CLK) disable iff (!rst_n)
    fetch_decode_flush == exp_fd_flush)
    else fail_value("fetch_decode_flush",
                    32'($sampled(fetch_decode_flush)), 32'($sampled(exp_fd_flush)));
  a_de_flush: assert property (@(posedge CLK) disable iff (!rst_n)
    decode_execute_flush == exp_de_flush)
    else fail_value("decode_execute_flush",
                    32'($sampled(decode_execute_flush)), 32'($sampled(exp_de_flush)));
  a_ec_flush: assert property (@(posedge CLK) disable iff (!rst_n)
    execute_commit_flush == exp_ec_flush)
    else fail_value("execute_commit_flush",
                    32'($sampled(execute_commit_flush)), 32'($sampled(exp_ec_flush)));
  a_epc: assert property (@(posedge CLK) disable iff (!rst_n) epc == exp_epc)
    else fail_value("epc", $sampled(epc), $sampled(exp_epc));
  a_badaddr: assert property (@(posedge CLK) disable iff (!rst_n) badaddr == exp_badaddr)
    else fail_value("badaddr", $sampled(badaddr), $sampled(exp_badaddr));
  a_pipe_clear: assert property (@(posedge CLK) disable iff (!rst_n)
    pipe_clear == exp_pipe_clear)
    else fail_value("pipe_clear", 32'($sampled(pipe_clear)), 32'($sampled(exp_pipe_clear)));
  a_wb_enable: assert property (@(posedge CLK) disable iff (!rst_n)
    wb_enable == (!exp_stall && !mispredict))
    else fail_value("wb_enable", 32'($sampled(wb_enable)),
                    32'($sampled(!exp_stall && !mispredict)));
  a_full: assert property (@(posedge CLK) disable iff (!rst_n)
    rob_full == (m_count == `ROB_DEPTH))
    else fail_value("rob_full", 32'($sampled(rob_full)), 32'($sampled(m_count == `ROB_DEPTH)));
  a_empty: assert property (@(posedge CLK) disable iff (!rst_n) rob_empty == (m_count == 0))
    else fail_value("rob_empty", 32'($sampled(rob_empty)), 32'($sampled(m_count == 0)));
  a_taken: assert property (@(posedge CLK) disable iff (!rst_n) intr_taken == exp_taken)
    else fail_value("intr_taken", 32'($sampled(intr_taken)), 32'($sampled(exp_taken)));

  // galois form with taps at 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic set_exception(input int k);
    {fault_insn, mal_insn, illegal_insn, fault_l, mal_l} = 5'b0;
    {fault_s, mal_s, breakpoint, env_m, ret} = 5'b0;
    case (k)
      0: fault_insn = 1'b1;
      1: mal_insn = 1'b1;
      2: illegal_insn = 1'b1;
      3: fault_l = 1'b1;
      4: mal_l = 1'b1;
      5: fault_s = 1'b1;
      6: mal_s = 1'b1;
      7: breakpoint = 1'b1;
      8: env_m = 1'b1;
      9: ret = 1'b1;
      default: ;
    endcase
  endtask

  // idle pipe with imem answering and nothing pending
  task automatic init_inputs();
    {ihit, i_mem_busy, decode_valid, wen, csr} = 5'b10000;
    fu_type = hazard_types_pkg::ALU_S;
    source_a_sel = hazard_types_pkg::SRC_IMM;
    source_b_sel = hazard_types_pkg::SRC_IMM;
    {rs1, rs2, rd, complete_rd} = '0;
    {busy_du, busy_ls, wb_port_conflict, mispredict, cb_flush} = 5'b0;
    {complete, commit, prv_intr, prv_insert_pc} = 4'b0;
    set_exception(10);
    {prv_priv_pc, pc_ex, pc_fe, cb_epc, badaddr_d} = '0;
  endtask

  // commit until the rob reports empty or the depth is used up
  task automatic drain_rob();
    int n;
    n = 0;
    @(negedge CLK);
    while (!rob_empty && n < `ROB_DEPTH + 2) begin
      commit = 1'b1;
      @(negedge CLK);
      n++;
    end
    commit = 1'b0;
    if (!rob_empty) begin
      $display("rob still not empty after %0d commits", n);
      err_count++;
    end
  endtask

  task automatic raw_hazard_seq();
    logic [31:0] v;
    logic [`REG_IDX_W-1:0] r;
    draw_bits(`REG_IDX_W, v);
    r = (v[`REG_IDX_W-1:0] == '0) ? `REG_IDX_W'(1) : v[`REG_IDX_W-1:0];
    // producer writes r
    @(negedge CLK);
    decode_valid = 1'b1;
    wen = 1'b1;
    rd = r;
    // consumer reads r as rs1
    @(negedge CLK);
    wen = 1'b0;
    rd = '0;
    rs1 = r;
    source_a_sel = hazard_types_pkg::SRC_RS;
    @(negedge CLK);
    source_a_sel = hazard_types_pkg::SRC_IMM;
    // register read again while r completes in this cycle
    @(negedge CLK);
    source_a_sel = hazard_types_pkg::SRC_RS;
    complete = 1'b1;
    complete_rd = r;
    @(negedge CLK);
    complete = 1'b0;
    @(negedge CLK);
    decode_valid = 1'b0;
    source_a_sel = hazard_types_pkg::SRC_IMM;
    rs1 = '0;
    drain_rob();
  endtask

  task automatic rob_fill_drain();
    @(negedge CLK);
    decode_valid = 1'b1;
    repeat (`ROB_DEPTH) @(negedge CLK);
    // decode held one more cycle under stall once full
    @(negedge CLK);
    decode_valid = 1'b0;
    commit = 1'b1;
    @(negedge CLK);
    commit = 1'b0;
    drain_rob();
  endtask

  task automatic structural_stalls();
    @(negedge CLK);
    decode_valid = 1'b1;
    fu_type = hazard_types_pkg::DIV_S;
    busy_du = 1'b1;
    @(negedge CLK);
    busy_du = 1'b0;
    fu_type = hazard_types_pkg::LOADSTORE_S;
    busy_ls = 1'b1;
    @(negedge CLK);
    busy_ls = 1'b0;
    fu_type = hazard_types_pkg::ALU_S;
    wb_port_conflict = 1'b1;
    // one alu op goes in ahead of the store
    @(negedge CLK);
    wb_port_conflict = 1'b0;
    @(negedge CLK);
    fu_type = hazard_types_pkg::LOADSTORE_S;
    source_a_sel = hazard_types_pkg::SRC_RS_ALT;
    @(negedge CLK);
    commit = 1'b1;
    // rob empty now so the store dispatches
    @(negedge CLK);
    commit = 1'b0;
    @(negedge CLK);
    decode_valid = 1'b0;
    fu_type = hazard_types_pkg::ALU_S;
    source_a_sel = hazard_types_pkg::SRC_IMM;
    drain_rob();
  endtask

  task automatic flush_seq();
    logic [31:0] v;
    logic [`REG_IDX_W-1:0] r1;
    logic [`REG_IDX_W-1:0] r2;
    @(negedge CLK);
    decode_valid = 1'b1;
    wen = 1'b1;
    draw_bits(`REG_IDX_W, v);
    r1 = v[`REG_IDX_W-1:0];
    rd = r1;
    @(negedge CLK);
    draw_bits(`REG_IDX_W, v);
    r2 = v[`REG_IDX_W-1:0];
    rd = r2;
    @(negedge CLK);
    {decode_valid, wen, rd} = '0;
    mispredict = 1'b1;
    @(negedge CLK);
    // redirect while imem misses so the sequencer waits for ihit
    ihit = 1'b0;
    i_mem_busy = 1'b1;
    @(negedge CLK);
    mispredict = 1'b0;
    @(negedge CLK);
    ihit = 1'b1;
    i_mem_busy = 1'b0;
    prv_insert_pc = 1'b1;
    draw_bits(`XLEN, v);
    prv_priv_pc = v;
    @(negedge CLK);
    prv_insert_pc = 1'b0;
    csr = 1'b1;
    @(negedge CLK);
    csr = 1'b0;
    cb_flush = 1'b1;
    @(negedge CLK);
    cb_flush = 1'b0;
    // both destinations read back as operands, none may still be busy
    rs1 = r1;
    rs2 = r2;
    source_a_sel = hazard_types_pkg::SRC_RS;
    source_b_sel = hazard_types_pkg::SRC_RS;
    @(negedge CLK);
    rs1 = '0;
    rs2 = '0;
    source_a_sel = hazard_types_pkg::SRC_IMM;
    source_b_sel = hazard_types_pkg::SRC_IMM;
  endtask

  task automatic interrupt_seq();
    int n;
    @(negedge CLK);
    decode_valid = 1'b1;
    repeat (3) @(negedge CLK);
    decode_valid = 1'b0;
    prv_intr = 1'b1;
    drain_rob();
    n = 0;
    while (!intr_taken && n < 4) begin
      @(negedge CLK);
      n++;
    end
    if (!intr_taken) begin
      $display("interrupt was not taken after the rob drained");
      err_count++;
    end
    // handler fetch misses for a few cycles
    prv_intr = 1'b0;
    ihit = 1'b0;
    repeat (3) @(negedge CLK);
    ihit = 1'b1;
    @(negedge CLK);
  endtask

  task automatic exception_pc_sweep();
    logic [31:0] v;
    // index 10 is the no-exception case
    for (int k = 0; k <= 10; k++) begin
      @(negedge CLK);
      draw_bits(`XLEN, v);
      pc_ex = v;
      draw_bits(`XLEN, v);
      pc_fe = v;
      draw_bits(`XLEN, v);
      cb_epc = v;
      draw_bits(`XLEN, v);
      badaddr_d = v;
      set_exception(k);
      // an interrupt request rides along and each commit exception masks it
      prv_intr = (k < 9);
    end
    @(negedge CLK);
    set_exception(10);
    prv_intr = 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %-16s %0d errors, sequencer in %s", tests_run, name,
             err_count - err_mark, m_state.name());
    err_mark = err_count;
  endtask

  initial begin
    err_count = 0;
    err_mark = 0;
    tests_run = 0;
    lfsr_state = 16'd37;
    init_inputs();
    @(posedge rst_n);
    raw_hazard_seq();
    finish_test("raw hazard");
    rob_fill_drain();
    finish_test("rob full/empty");
    structural_stalls();
    finish_test("structural");
    flush_seq();
    finish_test("flushes");
    interrupt_seq();
    finish_test("interrupt");
    exception_pc_sweep();
    finish_test("exception pc");
    repeat (2) @(negedge CLK);
    $display("summary: %0d tests, %0d errors", tests_run, err_count);
    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("run did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/hazard_types_pkg.sv
verilog/trap_types_pkg.sv
verilog/reg_busy_scoreboard.sv
verilog/rob_occupancy_counter.sv
verilog/trap_sequencer.sv
verilog/ooo_hazard_unit.sv
verilog/ooo_pipe_control.sv
tests/tb_clock_gen.sv
tests/tb_ooo_pipe_control.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then scan sim.log for the fail line
cd "$(dirname "$0")" &&
  rm -f sim.log &&
  verilator --binary --timing --assert --timescale 1ns/100ps -f src.f \
    --top-module tb_ooo_pipe_control -o tb_sim &&
  ./obj_dir/tb_sim | tee sim.log &&
  ! grep -q "Test failed" sim.log || exit 1
